// ==== hw/dct_pkg.sv ====
`default_nettype none

package dct_pkg;

    localparam int PIX_W   = 10;   // signed input pixel
    localparam int MID_W   = 16;   // row transform result in transpose memory
    localparam int OUT_W   = 13;   // final coefficient
    localparam int PAGE_AW = 7;    // page bit plus 6 in-block bits

    // cosine magnitudes, scaled by 2^16
    localparam logic [15:0] COEF_C3 = 16'd54491;
    localparam logic [15:0] COEF_S3 = 16'd36410;
    localparam logic [15:0] COEF_C4 = 16'd46341;
    localparam logic [15:0] COEF_C6 = 16'd25080;
    localparam logic [15:0] COEF_S6 = 16'd60547;
    localparam logic [15:0] COEF_C7 = 16'd12785;
    localparam logic [15:0] COEF_S7 = 16'd64277;

    // table word, stored raw and used as sign plus magnitude
    typedef union packed {
        logic [16:0] raw;
        struct packed {
            logic        neg;          // 1 for a negative coefficient
            logic [15:0] mag;
        } sm;
    } coef_word_u;

    localparam int ROW_FILL_CYC  = 8;  // samples per row
    localparam int D1D_LAT       = 6;  // latch strobe to output k=0
    localparam int COL_START_DLY = 2;  // last write and one ram read

endpackage

`default_nettype wire

// ==== hw/dct_1d.sv ====
`default_nettype none

module dct_1d #(
    parameter int IN_W     = 10,
    parameter int PROD_LSB = 9,
    parameter int RND_BITS = 3,
    parameter int OUT_W_P  = 16
) (
    input  logic               clk,
    input  logic               i_valid,
    input  logic               i_latch,
    input  logic [IN_W-1:0]    i_x,
    output logic [OUT_W_P-1:0] o_y,
    output logic               o_valid
);

    logic signed [IN_W-1:0]             sr [8];      // sr[0] newest sample
    logic signed [IN_W-1:0]             xr [8];      // row captured on i_latch
    logic [2:0]                         k_q;         // output index at add/sub stage
    logic [2:0]                         k_d1;
    logic [2:0]                         k_d2;        // index at multiplier stage
    logic                               run_q;
    logic [4:0]                         v_pipe;
    logic signed [IN_W:0]               as_q [4];    // pair sum or difference
    logic [IN_W:0]                      mag_w [4];
    logic                               sgn_q [4];
    logic [IN_W-1:0]                    mag_q [4];   // truncated magnitude
    dct_pkg::coef_word_u                cw [4];
    logic [IN_W+16:0]                   prod [4];
    logic [IN_W+16-PROD_LSB:0]          slc [4];
    logic signed [IN_W+16-PROD_LSB:0]   p_q [4];     // signed scaled products
    logic signed [IN_W+17-PROD_LSB:0]   s_q [2];
    logic signed [RND_BITS+OUT_W_P-1:0] z_q;         // full sum before rounding

    function automatic dct_pkg::coef_word_u cw_make(
        input logic        neg,
        input logic [15:0] mag
    );
        dct_pkg::coef_word_u w;
        w.raw = {neg, mag};
        return w;
    endfunction

    always_ff @(posedge clk) begin
        if (i_valid) begin
            sr[0] <= i_x;
            for (int i = 1; i < 8; i++) begin
                sr[i] <= sr[i-1];
            end
        end
        if (i_latch) begin
            xr <= sr;
        end
    end

    always_ff @(posedge clk) begin
        k_q    <= i_latch ? 3'd0 : k_q + 3'd1;   // free running, aligned on latch
        k_d1   <= k_q;
        k_d2   <= k_d1;
        run_q  <= i_latch | (run_q & (k_q != 3'd7));
        v_pipe <= {v_pipe[3:0], run_q};
    end

    // x[7-j] is the oldest of the pair, even k sums and odd k differences
    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            if (k_q[0]) begin
                as_q[j] <= xr[7-j] - xr[j];
            end else begin
                as_q[j] <= xr[7-j] + xr[j];
            end
            sgn_q[j] <= as_q[j][IN_W];
            mag_q[j] <= mag_w[j][IN_W-1:0];   // msb dropped
        end
    end

    always_comb begin
        case (k_d2)
            3'd0: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_C4);
                cw[1] = cw_make(1'b0, dct_pkg::COEF_C4);
                cw[2] = cw_make(1'b0, dct_pkg::COEF_C4);
                cw[3] = cw_make(1'b0, dct_pkg::COEF_C4);
            end
            3'd1: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_S7);
                cw[1] = cw_make(1'b0, dct_pkg::COEF_C3);
                cw[2] = cw_make(1'b0, dct_pkg::COEF_S3);
                cw[3] = cw_make(1'b0, dct_pkg::COEF_C7);
            end
            3'd2: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_S6);
                cw[1] = cw_make(1'b0, dct_pkg::COEF_C6);
                cw[2] = cw_make(1'b1, dct_pkg::COEF_C6);
                cw[3] = cw_make(1'b1, dct_pkg::COEF_S6);
            end
            3'd3: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_C3);
                cw[1] = cw_make(1'b1, dct_pkg::COEF_C7);
                cw[2] = cw_make(1'b1, dct_pkg::COEF_S7);
                cw[3] = cw_make(1'b1, dct_pkg::COEF_S3);
            end
            3'd4: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_C4);
                cw[1] = cw_make(1'b1, dct_pkg::COEF_C4);
                cw[2] = cw_make(1'b1, dct_pkg::COEF_C4);
                cw[3] = cw_make(1'b0, dct_pkg::COEF_C4);
            end
            3'd5: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_S3);
                cw[1] = cw_make(1'b1, dct_pkg::COEF_S7);
                cw[2] = cw_make(1'b0, dct_pkg::COEF_C7);
                cw[3] = cw_make(1'b0, dct_pkg::COEF_C3);
            end
            3'd6: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_C6);
                cw[1] = cw_make(1'b1, dct_pkg::COEF_S6);
                cw[2] = cw_make(1'b0, dct_pkg::COEF_S6);
                cw[3] = cw_make(1'b1, dct_pkg::COEF_C6);
            end
            default: begin
                cw[0] = cw_make(1'b0, dct_pkg::COEF_C7);
                cw[1] = cw_make(1'b1, dct_pkg::COEF_S3);
                cw[2] = cw_make(1'b0, dct_pkg::COEF_C3);
                cw[3] = cw_make(1'b1, dct_pkg::COEF_S7);
            end
        endcase
    end

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            mag_w[j] = as_q[j][IN_W] ? -as_q[j] : as_q[j];
            prod[j]  = mag_q[j] * cw[j].sm.mag;           // top bit always zero
            slc[j]   = prod[j][IN_W+16:PROD_LSB];
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            p_q[j] <= (sgn_q[j] ^ cw[j].sm.neg) ? -slc[j] : slc[j];
        end
        s_q[0] <= p_q[0] + p_q[1];   // sign extended adder tree
        s_q[1] <= p_q[2] + p_q[3];
        z_q    <= s_q[0] + s_q[1];
    end

    // round half up on the highest dropped bit
    assign o_y     = z_q[RND_BITS+OUT_W_P-1:RND_BITS] + z_q[RND_BITS-1];
    assign o_valid = v_pipe[4];

endmodule

`default_nettype wire

// ==== hw/dct_row_seq.sv ====
`default_nettype none

module dct_row_seq (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_start,
    output logic                        o_row_latch,
    output logic                        o_we,
    output logic                        o_blk_done,
    output logic                        o_last_in,
    output logic [dct_pkg::PAGE_AW-1:0] o_waddr,
    output logic                        o_page
);

    logic       fill_q;      // idle 0, filling 1
    logic [5:0] pix_q;       // index of the pixel on the input while filling
    logic [5:0] pix_idx;
    logic       pix_act;
    logic       dly_act_q;
    logic [2:0] dly_q;       // latch to write start countdown
    logic       wr_go;
    logic       we_q;
    logic [5:0] wa_q;        // row and k of the current write
    logic       page_q;      // page being filled

    assign pix_act   = fill_q | i_start;
    assign pix_idx   = fill_q ? pix_q : 6'd0;       // i_start carries pixel 0
    assign o_last_in = fill_q & (pix_q == 6'd63);
    assign wr_go     = dly_act_q & (dly_q == 3'd0);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fill_q      <= 1'b0;
            pix_q       <= '0;
            o_row_latch <= 1'b0;
            dly_act_q   <= 1'b0;
            dly_q       <= '0;
            we_q        <= 1'b0;
            wa_q        <= '0;
            page_q      <= 1'b0;
        end else begin
            if (pix_act) begin
                pix_q <= pix_idx + 6'd1;    // wraps to 0 after pixel 63
            end
            if (o_last_in) begin
                fill_q <= 1'b0;
            end else if (i_start) begin
                fill_q <= 1'b1;
            end
            // row is in the shift register one cycle after its 8th pixel
            o_row_latch <= pix_act & (pix_idx[2:0] == 3'(dct_pkg::ROW_FILL_CYC - 1));
            if (o_row_latch) begin
                dly_act_q <= 1'b1;
                dly_q     <= 3'(dct_pkg::D1D_LAT - 2);   // we is one flop later
            end else if (dly_act_q) begin
                dly_q <= dly_q - 3'd1;
                if (dly_q == 3'd0) begin
                    dly_act_q <= 1'b0;
                end
            end
            we_q <= wr_go | (we_q & (wa_q[2:0] != 3'd7));   // 8 writes per row
            if (we_q) begin
                wa_q <= wa_q + 6'd1;
            end
            if (o_blk_done) begin
                page_q <= ~page_q;
            end
        end
    end

    assign o_we       = we_q;
    assign o_waddr    = {page_q, wa_q};
    assign o_page     = page_q;
    assign o_blk_done = we_q & (wa_q == 6'd63);

endmodule

`default_nettype wire

// ==== hw/dct_col_timer.sv ====
`default_nettype none

module dct_col_timer (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_blk_done,
    input  logic                        i_page,
    output logic                        o_re,
    output logic                        o_row_latch,
    output logic                        o_dv,
    output logic                        o_pre_first_out,
    output logic [dct_pkg::PAGE_AW-1:0] o_raddr
);

    logic       pend_page_q;   // page finished by stage 1, not yet read
    logic       st_act_q;
    logic [1:0] st_q;          // start delay countdown
    logic       rd_go;
    logic       rd_act_q;
    logic [5:0] rc_q;          // read counter, row in low bits
    logic       rd_page_q;
    logic [1:0] lat_pipe_q;    // ram read plus shift register
    logic       dv_q;
    logic [5:0] dv_cnt_q;

    assign rd_go = st_act_q & (st_q == 2'd0);

    // 8th word of a column enters the shift register two cycles after its read
    assign o_pre_first_out = rd_act_q &
                             (rc_q == 6'(dct_pkg::ROW_FILL_CYC + dct_pkg::D1D_LAT));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_page_q <= 1'b0;
            st_act_q    <= 1'b0;
            st_q        <= '0;
            rd_act_q    <= 1'b0;
            rc_q        <= '0;
            rd_page_q   <= 1'b0;
            lat_pipe_q  <= '0;
            dv_q        <= 1'b0;
            dv_cnt_q    <= '0;
        end else begin
            if (i_blk_done) begin
                pend_page_q <= i_page;
                st_act_q    <= 1'b1;
                st_q        <= 2'(dct_pkg::COL_START_DLY - 2);
            end else if (st_act_q) begin
                st_q <= st_q - 2'd1;
                if (st_q == 2'd0) begin
                    st_act_q <= 1'b0;
                end
            end
            // page switches only after the previous block's last read
            if (rd_go) begin
                rd_page_q <= pend_page_q;
            end
            rd_act_q <= rd_go | (rd_act_q & (rc_q != 6'd63));
            if (rd_act_q) begin
                rc_q <= rc_q + 6'd1;
            end
            lat_pipe_q <= {lat_pipe_q[0],
                           rd_act_q & (rc_q[2:0] == 3'(dct_pkg::ROW_FILL_CYC - 1))};
            dv_q <= o_pre_first_out | (dv_q & (dv_cnt_q != 6'd63));   // 64 outputs
            if (dv_q) begin
                dv_cnt_q <= dv_cnt_q + 6'd1;
            end
        end
    end

    assign o_re        = rd_act_q;
    assign o_raddr     = {rd_page_q, rc_q[2:0], rc_q[5:3]};   // transposed order
    assign o_row_latch = lat_pipe_q[1];
    assign o_dv        = dv_q;

endmodule

`default_nettype wire

// ==== hw/dct_transpose_ram.sv ====
`default_nettype none

module dct_transpose_ram (
    input  logic                        clk,
    input  logic                        i_we,
    input  logic                        i_re,
    input  logic [dct_pkg::PAGE_AW-1:0] i_waddr,
    input  logic [dct_pkg::PAGE_AW-1:0] i_raddr,
    input  logic [dct_pkg::MID_W-1:0]   i_wdata,
    output logic [dct_pkg::MID_W-1:0]   o_rdata
);

    logic [dct_pkg::MID_W-1:0] mem [2**dct_pkg::PAGE_AW];   // two 64-word pages

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];   // holds between blocks
        end
    end

endmodule

`default_nettype wire

// ==== hw/dct2d.sv ====
`default_nettype none

module dct2d (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_start,
    input  logic [dct_pkg::PIX_W-1:0] i_xin,
    output logic                      o_last_in,
    output logic                      o_pre_first_out,
    output logic                      o_dv,
    output logic [dct_pkg::OUT_W-1:0] o_dout
);

    logic                        row_latch;
    logic                        col_latch;
    logic                        tm_we;
    logic                        tm_re;
    logic                        blk_done;
    logic                        tm_page;     // page stage 1 is filling
    logic [dct_pkg::PAGE_AW-1:0] tm_waddr;
    logic [dct_pkg::PAGE_AW-1:0] tm_raddr;
    logic [dct_pkg::MID_W-1:0]   tm_wdata;
    logic [dct_pkg::MID_W-1:0]   tm_rdata;

    dct_row_seq u_row_seq (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_start     (i_start),
        .o_row_latch (row_latch),
        .o_we        (tm_we),
        .o_blk_done  (blk_done),
        .o_last_in   (o_last_in),
        .o_waddr     (tm_waddr),
        .o_page      (tm_page)
    );

    dct_1d #(
        .IN_W     (dct_pkg::PIX_W),
        .PROD_LSB (9),
        .RND_BITS (3),
        .OUT_W_P  (dct_pkg::MID_W)
    ) u_row (
        .clk     (clk),
        .i_valid (1'b1),          // pixels arrive every cycle of a block
        .i_latch (row_latch),
        .i_x     (i_xin),
        .o_y     (tm_wdata),
        .o_valid ()
    );

    dct_transpose_ram u_tm (
        .clk     (clk),
        .i_we    (tm_we),
        .i_re    (tm_re),
        .i_waddr (tm_waddr),
        .i_raddr (tm_raddr),
        .i_wdata (tm_wdata),
        .o_rdata (tm_rdata)
    );

    dct_col_timer u_col_timer (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_blk_done      (blk_done),
        .i_page          (tm_page),
        .o_re            (tm_re),
        .o_row_latch     (col_latch),
        .o_dv            (o_dv),
        .o_pre_first_out (o_pre_first_out),
        .o_raddr         (tm_raddr)
    );

    dct_1d #(
        .IN_W     (dct_pkg::MID_W),
        .PROD_LSB (14),
        .RND_BITS (8),
        .OUT_W_P  (dct_pkg::OUT_W)
    ) u_col (
        .clk     (clk),
        .i_valid (1'b1),          // latch timing picks the column words
        .i_latch (col_latch),
        .i_x     (tm_rdata),
        .o_y     (o_dout),
        .o_valid ()
    );

endmodule

`default_nettype wire

// ==== tests/dct2d_chk.sv ====
`default_nettype none

module dct2d_chk (
    input logic clk,
    input logic i_arst_n,
    input logic i_dv,
    input logic i_pre_first_out,
    input logic i_last_in
);

    int fail_cnt = 0;   // polled by the testbench monitor

    a_pre_then_dv: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_pre_first_out |=> i_dv)
    else begin
        fail_cnt++;
        $error("o_pre_first_out was not followed by o_dv");
    end

    // burst ends 64 outputs after the last strobe
    a_burst_len: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(i_dv) |-> $past(i_pre_first_out, 65))
    else begin
        fail_cnt++;
        $error("o_dv fell without 64 outputs after the last o_pre_first_out");
    end

    a_reset_quiet: assert property (@(posedge clk)
        !i_arst_n |-> (!i_dv && !i_last_in && !i_pre_first_out))
    else begin
        fail_cnt++;
        $error("framing outputs not low during reset");
    end

endmodule

bind dct2d dct2d_chk u_chk (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_dv            (o_dv),
    .i_pre_first_out (o_pre_first_out),
    .i_last_in       (o_last_in)
);

`default_nettype wire

// ==== tests/dct2d_tb.sv ====
`default_nettype none

module dct2d_tb;

    localparam longint C3 = 54491,   // cosine magnitudes, 2^16 scale
                       S3 = 36410,
                       C4 = 46341,
                       C6 = 25080,
                       S6 = 60547,
                       C7 = 12785,
                       S7 = 64277;

    logic        clk;
    logic        i_arst_n;
    logic        i_start;
    logic [9:0]  i_xin;
    logic        o_last_in;
    logic        o_pre_first_out;
    logic        o_dv;
    logic [12:0] o_dout;

    int          exp_q [$];                  // expected coefficients in output order
    logic [31:0] rng_state = 32'h05a1_9d64;
    logic        exp_last;                   // high while pixel 63 is driven
    logic        exp_page;                   // page stage 1 should be filling
    logic        dv_prev;
    int          bursts;                     // o_dv rising edges
    int          out_cnt;
    int          n_blocks;

    dct2d dut0 (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_start         (i_start),
        .i_xin           (i_xin),
        .o_last_in       (o_last_in),
        .o_pre_first_out (o_pre_first_out),
        .o_dv            (o_dv),
        .o_dout          (o_dout)
    );

    always #2 clk = ~clk;   // period 4

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic longint sext(input longint v, input int w);
        return (v >= (longint'(1) << (w - 1))) ? v - (longint'(1) << w) : v;
    endfunction

    function automatic longint coef(input int k, input int j);
        longint t [8][4];
        t = '{'{C4, C4, C4, C4}, '{S7, C3, S3, C7}, '{S6, C6, -C6, -S6},
              '{C3, -C7, -S7, -S3}, '{C4, -C4, -C4, C4}, '{S3, -S7, C7, C3},
              '{C6, -S6, S6, -C6}, '{C7, -S3, C3, -S7}};
        return t[k][j];
    endfunction

    // one output of the 8-point transform, p in arrival order
    function automatic longint dct_point(input longint p [8], input int k, input int in_w,
                                         input int prod_lsb, input int rnd_bits,
                                         input int out_w);
        longint a;
        longint mag;
        longint c;
        longint slc;
        longint sum;
        sum = 0;
        for (int j = 0; j < 4; j++) begin
            a   = (k % 2) ? p[j] - p[7-j] : p[j] + p[7-j];        // odd k takes differences
            mag = (a < 0 ? -a : a) & ((longint'(1) << in_w) - 1);  // cut to input width
            c   = coef(k, j);
            slc = (mag * (c < 0 ? -c : c)) >>> prod_lsb;
            sum += ((a < 0) != (c < 0)) ? -slc : slc;
        end
        sum = (sum >>> rnd_bits) + ((sum >>> (rnd_bits - 1)) & 1);   // round half up
        return sum & ((longint'(1) << out_w) - 1);
    endfunction

    function automatic void ref_dct2d(input logic [9:0] pix [64]);
        longint p [8];
        longint mid [8][8];   // stage 1 words, [row][k]
        for (int r = 0; r < 8; r++) begin
            for (int i = 0; i < 8; i++) begin
                p[i] = sext(pix[8*r+i], 10);
            end
            for (int k = 0; k < 8; k++) begin
                mid[r][k] = sext(dct_point(p, k, 10, 9, 3, 16), 16);
            end
        end
        for (int c = 0; c < 8; c++) begin   // one column per stage 2 pass
            for (int r = 0; r < 8; r++) begin
                p[r] = mid[r][c];
            end
            for (int k = 0; k < 8; k++) begin
                exp_q.push_back(int'(dct_point(p, k, 16, 14, 8, 13)));
            end
        end
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h",
                                      name, got, exp));
        end
    endtask

    task automatic send_block(input logic [9:0] pix [64]);
        ref_dct2d(pix);
        n_blocks++;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            i_start  = (i == 0);   // start rides with pixel 0
            i_xin    = pix[i];
            exp_last = (i == 63);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            i_start  = 1'b0;
            i_xin    = '0;
            exp_last = 1'b0;
        end
    endtask

    task automatic wait_drain(input string what);
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0 || o_dv) begin
            @(negedge clk);
            cyc++;
            if (cyc > 1000) begin
                stop_with_error($sformatf("timeout waiting for the outputs of %s", what));
            end
        end
    endtask

    task automatic run_random(input int n, input bit with_gaps, input string what);
        logic [9:0] pix [64];
        int         gap;
        int         b0;
        int         breaks;   // gaps that must split the o_dv burst
        b0     = bursts;
        breaks = 0;
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < 64; i++) begin
                pix[i] = 10'(next_rand());
            end
            send_block(pix);
            gap = with_gaps ? int'(next_rand() % 41) : 0;
            if (b < n - 1 && gap != 0) begin
                breaks++;
            end
            idle(gap);
        end
        idle(1);
        wait_drain(what);
        check_eq("o_dv bursts", bursts - b0, breaks + 1);
    endtask

    task automatic run_fixed(input logic [9:0] even_pix, input logic [9:0] odd_pix,
                             input string what);
        logic [9:0] pix [64];
        for (int i = 0; i < 64; i++) begin
            pix[i] = i[0] ? odd_pix : even_pix;
        end
        send_block(pix);
        idle(1);
        wait_drain(what);
    endtask

    // monitor and comparison of every output cycle
    always @(posedge clk) begin
        if (i_arst_n) begin
            check_eq("o_last_in", o_last_in, exp_last);
            if (dut0.u_chk.fail_cnt != 0) begin
                stop_with_error("a bound assertion on the framing outputs failed");
            end
            if (dut0.blk_done) begin
                check_eq("tm_page", dut0.tm_page, exp_page);
                exp_page = ~exp_page;   // ping-pong
            end
            if (o_dv && !dv_prev) begin
                bursts++;
            end
            dv_prev = o_dv;
            if (o_dv) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("o_dv was high with no expected coefficient left");
                end else begin
                    check_eq("o_dout", o_dout, exp_q.pop_front());
                    out_cnt++;
                end
            end
        end
    end

    initial begin
        clk      = 1'b0;
        i_arst_n = 1'b1;
        i_start  = 1'b0;
        i_xin    = '0;
        exp_last = 1'b0;
        exp_page = 1'b0;
        dv_prev  = 1'b0;
        bursts   = 0;
        out_cnt  = 0;
        n_blocks = 0;
        #1 i_arst_n = 1'b0;   // clean falling edge for the async reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        run_random(1, 1'b0, "a single random block");
        run_fixed(10'h1ff, 10'h1ff, "the all maximum block");
        run_fixed(10'h1ff, 10'h200, "the alternating maximum and minimum block");
        run_fixed(10'h200, 10'h200, "the all minimum block");
        run_random(4, 1'b0, "four back to back blocks");
        run_random(6, 1'b1, "blocks with random gaps");
        if (exp_q.size() == 0 && out_cnt == 64 * n_blocks && dut0.u_chk.fail_cnt == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d outputs seen for %0d blocks, %0d never seen",
                                      out_cnt, n_blocks, exp_q.size()));
        end
    end

endmodule

`default_nettype wire

// ==== dct2d.f ====
hw/dct_pkg.sv
hw/dct_1d.sv
hw/dct_row_seq.sv
hw/dct_col_timer.sv
hw/dct_transpose_ram.sv
hw/dct2d.sv
tests/dct2d_chk.sv
tests/dct2d_tb.sv
